//--- design/fetch_pkg.sv
package fetch_pkg;

    // sv39 virtual addresses
    localparam int VADDR_W = 39;

    // one memory read is a 64-bit window, enough for two full instructions
    localparam int WINDOW_W = 64;

    // each decode slot carries up to one 32-bit instruction
    // a compressed instruction sits in the low 16 bits of its slot
    localparam int INST_W = 32;

    typedef logic [VADDR_W-1:0] vaddr_t;

    typedef logic [WINDOW_W-1:0] window_t;

    // first fetch address out of reset
    localparam vaddr_t RESET_ADDR = 39'h40_0000_0000;

    // major opcodes of the 32-bit control transfers
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // payload handed to decode
    // compressed has one bit per slot, bit 0 for inst0
    // count set means inst1 is a real instruction
    typedef struct packed {
        logic [INST_W-1:0] inst0;
        logic [INST_W-1:0] inst1;
        logic [1:0]        compressed;
        logic              count;
    } fetch_bundle_t;

    // sequencer states
    typedef enum logic [2:0] {
        // request sent last cycle, data may come back now
        FETCH = 3'h0,
        // still waiting on memory after a slow response
        CACHE = 3'h1,
        // decode stalled, latched bundle is shown
        VALID = 3'h2,
        // control transfer sent, waiting on the resolved target
        RESOL = 3'h3,
        // coming out of reset, nothing requested yet
        INIT  = 3'h4
    } fetch_state_t;

endpackage

//--- design/fetch_split.sv
module fetch_split import fetch_pkg::*; (
    input  window_t       i_window,
    output fetch_bundle_t o_bundle,
    output logic          o_branched,
    output logic [3:0]    o_pc_step
);

    // predecode of one slot for control transfers
    // the slot is already aligned so bits 1:0 are the quadrant
    function automatic logic is_ctrl(input logic [INST_W-1:0] inst);
        logic [2:0] funct3;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [6:0] opcode;
        logic       ctrl;
        // compressed field positions
        funct3 = inst[15:13];
        rs1    = inst[11:7];
        rs2    = inst[6:2];
        opcode = inst[6:0];
        ctrl   = 1'b0;
        case (inst[1:0])
            // quadrant 0 has only loads, stores and addi4spn
            2'b00: begin
                ctrl = 1'b0;
            end
            // c.j, c.beqz, c.bnez
            2'b01: begin
                ctrl = (funct3 == 3'b101) || (funct3 == 3'b110) || (funct3 == 3'b111);
            end
            // c.jr and c.jalr, rs2 zero keeps out c.mv and c.add
            // rs1 zero would be c.ebreak or reserved
            2'b10: begin
                ctrl = (funct3 == 3'b100) && (rs2 == 5'd0) && (rs1 != 5'd0);
            end
            // full 32-bit instruction
            default: begin
                ctrl = (opcode == OPC_BRANCH) || (opcode == OPC_JAL) || (opcode == OPC_JALR);
            end
        endcase
        return ctrl;
    endfunction

    logic [INST_W-1:0] inst0;
    logic [INST_W-1:0] inst1;
    logic              comp0;
    logic              comp1;
    logic              ctrl0;
    logic              ctrl1;
    logic              count;
    logic [3:0]        len0;
    logic [3:0]        len1;

    // slot 0 always starts at the window base
    assign inst0 = i_window[31:0];

    // anything but 11 in the low bits is a 16-bit instruction
    assign comp0 = inst0[1:0] != 2'b11;

    // slot 1 begins right after slot 0
    // if slot 0 is compressed, the top 16 bits of the window go unused
    assign inst1 = comp0 ? i_window[47:16] : i_window[63:32];

    assign comp1 = inst1[1:0] != 2'b11;

    assign ctrl0 = is_ctrl(inst0);
    assign ctrl1 = is_ctrl(inst1);

    // no speculation past a control transfer in slot 0
    // slot 1 is dropped and refetched after resolution
    assign count = !ctrl0;

    // byte length of each slot
    assign len0 = comp0 ? 4'd2 : 4'd4;
    assign len1 = comp1 ? 4'd2 : 4'd4;

    always_comb begin
        o_bundle.inst0      = inst0;
        // a dropped slot 1 goes out as zero
        o_bundle.inst1      = count ? inst1 : '0;
        o_bundle.compressed = {count & comp1, comp0};
        o_bundle.count      = count;
    end

    // either slot stops the fetch stream until the target comes back
    // when slot 0 transfers, slot 1 no longer matters
    assign o_branched = ctrl0 || ctrl1;

    // step is 2, 4, 6 or 8 bytes
    assign o_pc_step = count ? (len0 + len1) : len0;

endmodule

//--- design/fetch_sequencer.sv
module fetch_sequencer import fetch_pkg::*; (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_imem_valid,
    output logic          o_imem_ren,
    output vaddr_t        o_imem_raddr,
    input  fetch_bundle_t i_bundle,
    input  logic          i_branched,
    input  logic [3:0]    i_pc_step,
    input  logic          i_fetch_ready,
    output logic          o_fetch_valid,
    output fetch_bundle_t o_fetch_bundle,
    input  logic          i_branch_valid,
    input  vaddr_t        i_branch_target
);

    fetch_state_t  state;
    fetch_state_t  next_state;
    vaddr_t        pc;
    vaddr_t        next_pc;
    logic          started;
    logic          hold;
    logic          sent;
    logic          cur_branched;
    logic [3:0]    cur_step;
    fetch_bundle_t hold_bundle;
    logic          hold_branched;
    logic [3:0]    hold_step;

    // set on the first clock after reset is released
    // keeps INIT idle while reset is still asserted
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= INIT;
        end else begin
            state <= next_state;
        end
    end

    // pc is the address of the bundle in flight or on display
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= next_pc;
        end
    end

    // capture every returned window's predecode results
    // only read back in VALID, where no new data can arrive
    always_ff @(posedge i_clk) begin
        if (i_imem_valid) begin
            hold_bundle   <= i_bundle;
            hold_branched <= i_branched;
            hold_step     <= i_pc_step;
        end
    end

    // show the latched bundle while decode stalls
    assign hold = state == VALID;

    // live data only exists in the cycle memory answers
    assign o_fetch_valid  = i_imem_valid || hold;
    assign o_fetch_bundle = hold ? hold_bundle : i_bundle;

    // handshake with decode
    assign sent = o_fetch_valid && i_fetch_ready;

    // predecode of whatever bundle is on the output
    assign cur_branched = hold ? hold_branched : i_branched;
    assign cur_step     = hold ? hold_step : i_pc_step;

    always_comb begin
        next_state = state;
        case (state)
            // first request goes out one cycle after reset release
            INIT: begin
                next_state = started ? FETCH : INIT;
            end
            // waiting on memory
            // accepted straight away: fetch on, or wait for a target
            // not accepted: latch and stall
            FETCH, CACHE: begin
                if (i_imem_valid) begin
                    if (sent) begin
                        next_state = cur_branched ? RESOL : FETCH;
                    end else begin
                        next_state = VALID;
                    end
                end else begin
                    next_state = CACHE;
                end
            end
            // latched bundle waits for decode
            VALID: begin
                if (sent) begin
                    next_state = cur_branched ? RESOL : FETCH;
                end
            end
            // nothing moves until the branch unit reports the target
            RESOL: begin
                next_state = i_branch_valid ? FETCH : RESOL;
            end
            default: begin
                next_state = INIT;
            end
        endcase
    end

    // target only counts in RESOL
    // elsewhere the pc steps past an accepted bundle or stays put
    always_comb begin
        next_pc = pc;
        if (state == RESOL) begin
            if (i_branch_valid) begin
                next_pc = i_branch_target;
            end
        end else if (sent) begin
            next_pc = pc + vaddr_t'(cur_step);
        end
    end

    // one pulse per entry into FETCH
    // every path into FETCH either starts fresh or retires the
    // outstanding request in the same cycle
    // back-to-back on a one-cycle memory gives one bundle per clock
    assign o_imem_ren = next_state == FETCH;

    // request goes to the address the pc is about to take
    assign o_imem_raddr = next_pc;

endmodule

//--- design/fetch_top.sv
module fetch_top import fetch_pkg::*; (
    input  logic          i_clk,
    input  logic          i_rst_n,
    // instruction memory
    output logic          o_imem_ren,
    output vaddr_t        o_imem_raddr,
    input  logic          i_imem_valid,
    input  window_t       i_imem_rdata,
    // decode
    output logic          o_fetch_valid,
    output fetch_bundle_t o_fetch_bundle,
    input  logic          i_fetch_ready,
    // branch resolution
    input  logic          i_branch_valid,
    input  vaddr_t        i_branch_target
);

    fetch_bundle_t split_bundle;
    logic          split_branched;
    logic [3:0]    split_step;

    // pure combinational look at the raw memory window
    fetch_split u_split (
        .i_window   (i_imem_rdata),
        .o_bundle   (split_bundle),
        .o_branched (split_branched),
        .o_pc_step  (split_step)
    );

    // control, pc and the hold register
    fetch_sequencer u_sequencer (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_imem_valid    (i_imem_valid),
        .o_imem_ren      (o_imem_ren),
        .o_imem_raddr    (o_imem_raddr),
        .i_bundle        (split_bundle),
        .i_branched      (split_branched),
        .i_pc_step       (split_step),
        .i_fetch_ready   (i_fetch_ready),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_bundle  (o_fetch_bundle),
        .i_branch_valid  (i_branch_valid),
        .i_branch_target (i_branch_target)
    );

endmodule

//--- dv/fetch_assertions.sv
module fetch_assertions import fetch_pkg::*; (
    input logic          i_clk,
    input logic          i_rst_n,
    input logic          i_imem_valid,
    input logic          o_imem_ren,
    input logic          i_fetch_ready,
    input logic          o_fetch_valid,
    input fetch_bundle_t o_fetch_bundle
);

    timeunit 1ns;
    timeprecision 100ps;

    logic outstanding;

    // a request is open from its pulse until the memory answers
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            outstanding <= 1'b0;
        end else if (o_imem_ren) begin
            outstanding <= 1'b1;
        end else if (i_imem_valid) begin
            outstanding <= 1'b0;
        end
    end

    quiet_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !o_imem_ren && !o_fetch_valid)
        else $error("request or valid during reset");

    // a new pulse is fine only in the cycle the old request retires
    one_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_imem_ren |-> !outstanding || i_imem_valid)
        else $error("request while another is outstanding");

    held_bundle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_fetch_valid && !i_fetch_ready |=> o_fetch_valid && $stable(o_fetch_bundle))
        else $error("bundle changed under back-pressure");

endmodule

bind fetch_sequencer fetch_assertions u_assertions (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_imem_valid   (i_imem_valid),
    .o_imem_ren     (o_imem_ren),
    .i_fetch_ready  (i_fetch_ready),
    .o_fetch_valid  (o_fetch_valid),
    .o_fetch_bundle (o_fetch_bundle)
);

//--- dv/fetch_checker.sv
module fetch_checker import fetch_pkg::*; (
    input logic          i_clk,
    input logic          i_rst_n,
    input logic          o_imem_ren,
    input vaddr_t        o_imem_raddr,
    input logic          i_imem_valid,
    input window_t       i_imem_rdata,
    input logic          o_fetch_valid,
    input fetch_bundle_t o_fetch_bundle,
    input logic          i_fetch_ready,
    input logic          i_branch_valid,
    input vaddr_t        i_branch_target
);

    timeunit 1ns;
    timeprecision 100ps;

    int      errors;
    int      transfers;
    vaddr_t  exp_pc;
    logic    wait_br;
    window_t pending [$];

    // control transfer test on an aligned instruction
    function automatic logic transfers_ctrl(input logic [31:0] w);
        if (w[1:0] == 2'b11) begin
            return w[6:0] inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
        end
        if (w[1:0] == 2'b01) begin
            return w[15:13] >= 3'b101;
        end
        if (w[1:0] == 2'b10) begin
            return w[15:13] == 3'b100 && w[6:2] == 5'd0 && w[11:7] != 5'd0;
        end
        return 1'b0;
    endfunction

    // expected bundle, step and branch flag for one window
    task automatic predict(input window_t w, output fetch_bundle_t b, output int step,
                           output logic br);
        int          len0;
        int          len1;
        logic [31:0] s1;
        len0 = (w[1:0] == 2'b11) ? 4 : 2;
        s1   = 32'(w >> (len0 * 8));
        len1 = (s1[1:0] == 2'b11) ? 4 : 2;
        b.inst0 = w[31:0];
        if (transfers_ctrl(w[31:0])) begin
            b.inst1      = '0;
            b.compressed = {1'b0, len0 == 2};
            b.count      = 1'b0;
            step         = len0;
            br           = 1'b1;
        end else begin
            b.inst1      = s1;
            b.compressed = {len1 == 2, len0 == 2};
            b.count      = 1'b1;
            step         = len0 + len1;
            br           = transfers_ctrl(s1);
        end
    endtask

    initial begin
        errors    = 0;
        transfers = 0;
        exp_pc    = RESET_ADDR;
        wait_br   = 1'b0;
    end

    always @(posedge i_clk) begin
        fetch_bundle_t eb;
        int            step;
        logic          br;
        window_t       w;
        if (i_rst_n) begin
            if (i_imem_valid) begin
                pending.push_back(i_imem_rdata);
            end
            if (o_fetch_valid && pending.size() == 0) begin
                $display("fetch valid seen with no memory answer behind it at %0t", $time);
                errors++;
            end
            // handshake first since it moves the expected address
            if (o_fetch_valid && i_fetch_ready && pending.size() > 0) begin
                w = pending.pop_front();
                predict(w, eb, step, br);
                if (o_fetch_bundle !== eb) begin
                    $display("ERR t=%0t o_fetch_bundle exp=%h got=%h", $time, eb,
                             o_fetch_bundle);
                    errors++;
                end
                $display("test %0d: window %h at pc %h, step %0d%s", transfers, w, exp_pc,
                         step, br ? ", branch" : "");
                transfers++;
                if (br) begin
                    wait_br = 1'b1;
                end else begin
                    exp_pc = exp_pc + vaddr_t'(step);
                    // the next request goes out together with the accepted bundle
                    if (!o_imem_ren) begin
                        $display("no memory request with the accepted bundle at %0t",
                                 $time);
                        errors++;
                    end
                end
            end
            if (i_branch_valid && wait_br) begin
                exp_pc  = i_branch_target;
                wait_br = 1'b0;
                // refetch starts in the cycle the target arrives
                if (!o_imem_ren) begin
                    $display("no memory request with the branch target at %0t", $time);
                    errors++;
                end
            end
            if (o_imem_ren) begin
                if (wait_br) begin
                    $display("memory request issued while a branch was unresolved at %0t",
                             $time);
                    errors++;
                end else if (o_imem_raddr !== exp_pc) begin
                    $display("ERR t=%0t o_imem_raddr exp=%h got=%h", $time, exp_pc,
                             o_imem_raddr);
                    errors++;
                end
            end
        end
    end

endmodule

//--- dv/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 12;
    localparam int MAX_WAIT = 60;

    // one scenario step
    // is_br marks a row whose bundle ends the stream
    typedef struct packed {
        window_t    window;
        logic [3:0] latency;
        logic [3:0] ready_low;
        vaddr_t     target;
        logic [3:0] br_delay;
        logic       is_br;
    } row_t;

    logic          i_clk;
    logic          i_rst_n;
    logic          o_imem_ren;
    vaddr_t        o_imem_raddr;
    logic          i_imem_valid;
    window_t       i_imem_rdata;
    logic          o_fetch_valid;
    fetch_bundle_t o_fetch_bundle;
    logic          i_fetch_ready;
    logic          i_branch_valid;
    vaddr_t        i_branch_target;

    row_t rows [NUM_ROWS];
    int   seed;
    logic req_seen;
    logic timed_out;

    fetch_top u_fetch_top (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .o_imem_ren      (o_imem_ren),
        .o_imem_raddr    (o_imem_raddr),
        .i_imem_valid    (i_imem_valid),
        .i_imem_rdata    (i_imem_rdata),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_bundle  (o_fetch_bundle),
        .i_fetch_ready   (i_fetch_ready),
        .i_branch_valid  (i_branch_valid),
        .i_branch_target (i_branch_target)
    );

    fetch_checker u_checker (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .o_imem_ren      (o_imem_ren),
        .o_imem_raddr    (o_imem_raddr),
        .i_imem_valid    (i_imem_valid),
        .i_imem_rdata    (i_imem_rdata),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_bundle  (o_fetch_bundle),
        .i_fetch_ready   (i_fetch_ready),
        .i_branch_valid  (i_branch_valid),
        .i_branch_target (i_branch_target)
    );

    always begin
        #10 i_clk = ~i_clk;
    end

    // inputs change on the falling edge and outputs are read on the rising edge
    task automatic drive_cycle(input logic valid, input window_t data, input logic ready,
                               input logic bvalid, input vaddr_t target);
        @(negedge i_clk);
        i_imem_valid    = valid;
        i_imem_rdata    = data;
        i_fetch_ready   = ready;
        i_branch_valid  = bvalid;
        i_branch_target = target;
        @(posedge i_clk);
    endtask

    // ready toggles at random while nothing is offered
    task automatic idle_cycle();
        logic [31:0] r;
        r = $random(seed);
        drive_cycle(1'b0, '0, r[0], 1'b0, '0);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic run_row(input row_t row);
        int k;
        // find the request this row answers
        k = 0;
        while (!req_seen && !timed_out) begin
            idle_cycle();
            req_seen = o_imem_ren;
            k++;
            if (k > MAX_WAIT) begin
                report_timeout("a memory request");
            end
        end
        if (!timed_out) begin
            req_seen = 1'b0;
            // the answer lands latency cycles after the request edge
            for (k = 1; k < int'(row.latency); k++) begin
                idle_cycle();
            end
            // answer and then hold ready low for ready_low cycles
            for (k = 0; k <= int'(row.ready_low); k++) begin
                drive_cycle(k == 0, row.window, k == int'(row.ready_low), 1'b0, '0);
            end
            req_seen = o_imem_ren;
            if (row.is_br) begin
                for (k = 0; k < int'(row.br_delay); k++) begin
                    idle_cycle();
                end
                drive_cycle(1'b0, '0, 1'b1, 1'b1, row.target);
                req_seen = o_imem_ren;
            end
        end
    endtask

    initial begin
        int i;
        int errors;
        // window, latency, ready low, target, branch delay, branch row
        rows[0]  = '{64'h0085_0085_0085_0085, 4'd1, 4'd0, '0, 4'd0, 1'b0};
        rows[1]  = '{64'h0010_0093_0010_0093, 4'd1, 4'd0, '0, 4'd0, 1'b0};
        rows[2]  = '{64'h0000_0010_0093_0085, 4'd2, 4'd1, '0, 4'd0, 1'b0};
        rows[3]  = '{64'h1234_0085_0010_0093, 4'd3, 4'd3, '0, 4'd0, 1'b0};
        rows[4]  = '{64'h0010_0093_0000_006f, 4'd1, 4'd0, 39'h40_0000_1000, 4'd2, 1'b1};
        rows[5]  = '{64'h0085_0085_0085_a001, 4'd4, 4'd2, 39'h40_0000_2002, 4'd0, 1'b1};
        rows[6]  = '{64'h0000_0063_0010_0093, 4'd2, 4'd0, 39'h00_0000_0100, 4'd3, 1'b1};
        rows[7]  = '{64'h0000_0000_8082_0085, 4'd1, 4'd1, 39'h7f_ffff_fff0, 4'd1, 1'b1};
        rows[8]  = '{64'h0085_0085_0085_0085, 4'd1, 4'd0, '0, 4'd0, 1'b0};
        rows[9]  = '{64'hffff_0085_0010_0093, 4'd5, 4'd0, '0, 4'd0, 1'b0};
        rows[10] = '{64'h0000_0010_0093_0085, 4'd1, 4'd2, '0, 4'd0, 1'b0};
        rows[11] = '{64'h0010_0093_0010_0093, 4'd1, 4'd0, '0, 4'd0, 1'b0};
        seed            = 68154;
        req_seen        = 1'b0;
        timed_out       = 1'b0;
        i_clk           = 1'b0;
        i_rst_n         = 1'b0;
        i_imem_valid    = 1'b0;
        i_imem_rdata    = '0;
        i_fetch_ready   = 1'b0;
        i_branch_valid  = 1'b0;
        i_branch_target = '0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        for (i = 0; i < NUM_ROWS && !timed_out; i++) begin
            run_row(rows[i]);
        end
        repeat (3) idle_cycle();
        // counters settle after the last rising edge
        @(negedge i_clk);
        errors = u_checker.errors;
        if (timed_out) begin
            errors++;
        end
        if (u_checker.transfers != NUM_ROWS) begin
            $display("expected %0d transfers to decode but saw %0d", NUM_ROWS,
                     u_checker.transfers);
            errors++;
        end
        $display("tests %0d, transfers %0d, errors %0d", NUM_ROWS, u_checker.transfers,
                 errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
design/fetch_pkg.sv
design/fetch_split.sv
design/fetch_sequencer.sv
design/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= fetch_tb
FILELIST  ?= sources.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
